//--- all.f
+incdir+logic
logic/mf2_pkg.sv
logic/mf2_bus_if.sv
logic/mf2_control.sv
logic/mf2_snoop.sv
logic/mf2_ram.sv
logic/mf2_unit.sv
sim/mf2_unit_chk.sv
sim/mf2_unit_tb.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/1ps
TOP        = mf2_unit_tb
FILELIST   = all.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = ** FAIL **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -qF -- '$(FAIL_MSG)' $(LOG); then echo "Simulation reported errors"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/mf2_unit_tb.sv
/*
 * Multiface Two unit testbench
 * NMI, paging, snooped stores and window RAM against a reference model
 */
`timescale 1ns/1ps
`default_nettype none

`include "mf2_cfg.svh"

module mf2_unit_tb;
	import mf2_pkg::*;

	logic       clk_sys = 1'b0;
	logic       reset;
	mf2_mode_t  mode;
	logic       key_nmi;
	logic       m1;
	logic       io_wr;
	logic       mem_wr;
	logic       mem_rd;
	cpu_addr_t  cpu_addr;
	cpu_data_t  cpu_dout;
	logic       nmi;
	logic       mf2_rom_en;
	logic       mf2_ram_en;
	cpu_data_t  mf2_dout;

	cpu_data_t  model_ram [`MF2_RAM_DEPTH];
	mf2_addr_t  slots [$];      // Shadow slots hit so far
	logic [4:0] pen_m;
	logic [3:0] crtc_m;
	cpu_data_t  cmp_exp;
	int         rd_req = 0;
	int         rd_done = 0;
	int         chk_main = 0;
	int         err_main = 0;
	int         chk_cmp = 0;
	int         err_cmp = 0;
	int         err_base = 0;
	int         n_tests = 0;
	string      test_name;

	mf2_unit u_mf2_unit (.*);

	always #50 clk_sys = ~clk_sys;

	//////////////////// Reference model
	function automatic mf2_addr_t shadow_slot(input logic [7:0] port, input cpu_data_t d);
		case (port)
			`MF2_PORT_GA: begin
				case (d[7:6])
					2'b00: return `MF2_LOC_PEN;
					2'b01: return pen_m[4] ? `MF2_LOC_BORDER
						: `MF2_LOC_PALETTE_BASE + {9'd0, pen_m[3:0]};
					2'b10: return `MF2_LOC_MODE;
					default: return `MF2_LOC_BANK;
				endcase
			end
			`MF2_PORT_CRTC_SEL: return `MF2_LOC_CRTC_SEL;
			`MF2_PORT_CRTC_VAL: return `MF2_LOC_CRTC_BASE + {9'd0, crtc_m};
			`MF2_PORT_PPI:      return `MF2_LOC_PPI;
			default:            return `MF2_LOC_UROM;
		endcase
	endfunction

	// Only the RAM window answers, everything else floats high
	function automatic cpu_data_t expected_read(input cpu_addr_t a);
		if (a[15:13] == 3'b001)
			return model_ram[a[12:0]];
		return 8'hFF;
	endfunction

	//////////////////// Compare
	task automatic check_data(input string name, input cpu_data_t got, input cpu_data_t exp);
		chk_cmp++;
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			err_cmp++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		chk_main++;
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			err_main++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		err_main++;
	endtask

	always @(negedge clk_sys) begin
		if (rd_done != rd_req) begin
			check_data("mf2_dout", mf2_dout, cmp_exp);
			rd_done++;
		end
	end

	task automatic begin_test(input string name);
		test_name = name;
		err_base  = err_main + err_cmp;
	endtask

	task automatic end_test();
		n_tests++;
		$display("Test %0d %s: %0d errors", n_tests, test_name, err_main + err_cmp - err_base);
	endtask

	//////////////////// Bus cycles
	task automatic apply_reset(input mf2_mode_t m);
		@(posedge clk_sys);
		mode  <= m;
		reset <= 1'b1;
		repeat (2) @(posedge clk_sys);
		reset  <= 1'b0;
		pen_m  = '0;
		crtc_m = '0;
	endtask

	// Address held until the m1 edge has been seen
	task automatic fetch(input cpu_addr_t a);
		@(posedge clk_sys);
		cpu_addr <= a;
		m1       <= 1'b1;
		repeat (2) @(posedge clk_sys);
		m1 <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic io_write(input cpu_addr_t a, input cpu_data_t d);
		@(posedge clk_sys);
		cpu_addr <= a;
		cpu_dout <= d;
		io_wr    <= 1'b1;
		repeat (2) @(posedge clk_sys);
		io_wr <= 1'b0;
		repeat (2) @(posedge clk_sys);    // Store lands in RAM
	endtask

	task automatic snoop_write(input cpu_addr_t a, input cpu_data_t d);
		mf2_addr_t loc;
		io_write(a, d);
		loc = shadow_slot(a[15:8], d);
		model_ram[loc] = d;
		slots.push_back(loc);
		if (a[15:8] == `MF2_PORT_GA && d[7:6] == 2'b00)
			pen_m = d[4:0];
		if (a[15:8] == `MF2_PORT_CRTC_SEL)
			crtc_m = d[3:0];
	endtask

	task automatic mem_write(input cpu_addr_t a, input cpu_data_t d);
		@(posedge clk_sys);
		cpu_addr <= a;
		cpu_dout <= d;
		mem_wr   <= 1'b1;
		@(posedge clk_sys);
		mem_wr <= 1'b0;
		model_ram[a[12:0]] = d;
	endtask

	task automatic mem_read(input cpu_addr_t a);
		int n;
		@(posedge clk_sys);
		cpu_addr <= a;
		mem_rd   <= 1'b1;
		repeat (3) @(posedge clk_sys);
		cmp_exp = expected_read(a);
		rd_req++;                          // Compared on the next falling edge
		n = 0;
		while (rd_done != rd_req && n < 8) begin
			@(posedge clk_sys);
			n++;
		end
		if (rd_done != rd_req)
			report_timeout("the read compare");
		mem_rd <= 1'b0;
	endtask

	task automatic wait_nmi(input int limit, output logic seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < limit) begin
			@(negedge clk_sys);
			seen = nmi;
			n++;
		end
	endtask

	// ROM window at 0x0100, RAM window at 0x2100
	task automatic check_paged(input logic exp);
		@(posedge clk_sys);
		cpu_addr <= 16'h0100;
		@(negedge clk_sys);
		check_flag("mf2_rom_en", mf2_rom_en, exp);
		check_flag("mf2_ram_en", mf2_ram_en, 1'b0);
		@(posedge clk_sys);
		cpu_addr <= 16'h2100;
		@(negedge clk_sys);
		check_flag("mf2_ram_en", mf2_ram_en, exp);
		check_flag("mf2_rom_en", mf2_rom_en, 1'b0);
	endtask

	//////////////////// Tests
	initial begin
		logic       seen;
		logic [7:0] port;
		cpu_addr_t  a;
		cpu_addr_t  addrs [$];

		void'($urandom(87));
		reset    <= 1'b1;
		mode     <= 2'd0;
		key_nmi  <= 1'b0;
		m1       <= 1'b0;
		io_wr    <= 1'b0;
		mem_wr   <= 1'b0;
		mem_rd   <= 1'b0;
		cpu_addr <= '0;
		cpu_dout <= '0;

		begin_test("nmi enabled");
		apply_reset(2'd0);
		@(posedge clk_sys);
		key_nmi <= 1'b1;
		wait_nmi(8, seen);
		if (!seen)
			report_timeout("nmi after the key press");
		@(posedge clk_sys);
		key_nmi <= 1'b0;
		fetch(`MF2_NMI_VECTOR);
		@(negedge clk_sys);
		check_flag("nmi", nmi, 1'b0);
		check_paged(1'b1);
		end_test();

		begin_test("nmi disabled");
		apply_reset(2'd2);
		@(posedge clk_sys);
		key_nmi <= 1'b1;
		wait_nmi(20, seen);
		check_flag("nmi", seen, 1'b0);
		@(posedge clk_sys);
		key_nmi <= 1'b0;
		end_test();

		begin_test("snooped stores");
		apply_reset(2'd0);
		repeat (24) begin
			case ($urandom_range(0, 4))
				0: port = `MF2_PORT_GA;
				1: port = `MF2_PORT_CRTC_SEL;
				2: port = `MF2_PORT_CRTC_VAL;
				3: port = `MF2_PORT_PPI;
				default: port = `MF2_PORT_UROM;
			endcase
			snoop_write({port, cpu_data_t'($urandom)}, cpu_data_t'($urandom));
		end
		io_write(16'hFEE8, 8'h00);          // Page in to see the shadows
		foreach (slots[i])
			mem_read(16'h2000 | {3'b000, slots[i]});
		end_test();

		begin_test("window ram");
		repeat (16) begin
			a = 16'h2000 | cpu_addr_t'($urandom_range(0, 16'h1FFF));
			mem_write(a, cpu_data_t'($urandom));
			addrs.push_back(a);
		end
		foreach (addrs[i])
			mem_read(addrs[i]);
		repeat (4)
			mem_read(cpu_addr_t'($urandom_range(16'h4000, 16'hFFFF)));
		mem_read(16'h0123);
		end_test();

		begin_test("io paging and hiding");
		io_write(16'hFEEA, 8'h00);
		check_paged(1'b0);
		io_write(16'hFEE8, 8'h00);
		check_paged(1'b1);
		fetch(`MF2_HIDE_VECTOR);
		io_write(16'hFEE8, 8'h00);          // Hidden but still paged in
		check_paged(1'b1);
		io_write(16'hFEEA, 8'h00);
		io_write(16'hFEE8, 8'h00);          // Hidden, so no effect
		check_paged(1'b0);
		end_test();

		begin_test("reset state");
		apply_reset(2'd1);
		@(negedge clk_sys);
		check_flag("nmi", nmi, 1'b0);
		io_write(16'hFEE8, 8'h00);
		check_paged(1'b0);
		mem_read(16'h0100);
		end_test();

		$display("%0d tests, %0d checks, %0d errors", n_tests, chk_main + chk_cmp,
			err_main + err_cmp);
		if (err_main + err_cmp == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/mf2_unit_chk.sv
/*
 * Multiface Two bus rule checks
 * Enable exclusion, NMI release and idle read data
 */
`timescale 1ns/1ps
`default_nettype none

`include "mf2_cfg.svh"

module mf2_unit_chk (
	input logic               clk_sys,
	input logic               reset,
	input logic               m1,
	input logic               mem_rd,
	input mf2_pkg::cpu_addr_t cpu_addr,
	input logic               nmi,
	input logic               mf2_rom_en,
	input logic               mf2_ram_en,
	input mf2_pkg::cpu_data_t mf2_dout
);

	// ROM and RAM windows never overlap
	enables_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(mf2_rom_en && mf2_ram_en))
		else $error("mf2_rom_en and mf2_ram_en both high");

	// State register lags the m1 edge by one cycle
	nmi_release: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(nmi) |-> $past(reset) || ($past(m1, 2) && $past(cpu_addr) == `MF2_NMI_VECTOR))
		else $error("nmi fell without a fetch at the NMI vector");

	idle_dout: assert property (@(posedge clk_sys) disable iff (reset)
		!mem_rd |-> mf2_dout == 8'hFF)
		else $error("mf2_dout not 0xFF with mem_rd low");

endmodule

bind mf2_unit mf2_unit_chk u_mf2_unit_chk (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.m1         (m1),
	.mem_rd     (mem_rd),
	.cpu_addr   (cpu_addr),
	.nmi        (nmi),
	.mf2_rom_en (mf2_rom_en),
	.mf2_ram_en (mf2_ram_en),
	.mf2_dout   (mf2_dout)
);

`default_nettype wire

//--- logic/mf2_unit.sv
/*
 * Multiface Two freeze cartridge
 * NMI button, paging, register snooping and 8 KB RAM on the Z80 bus
 */
`timescale 1ns/1ps
`default_nettype none

module mf2_unit (
	input  logic               clk_sys,
	input  logic               reset,
	input  mf2_pkg::mf2_mode_t mode,
	input  logic               key_nmi,
	input  logic               m1,
	input  logic               io_wr,
	input  logic               mem_wr,
	input  logic               mem_rd,
	input  mf2_pkg::cpu_addr_t cpu_addr,
	input  mf2_pkg::cpu_data_t cpu_dout,
	output logic               nmi,
	output logic               mf2_rom_en,
	output logic               mf2_ram_en,
	output mf2_pkg::cpu_data_t mf2_dout
);
	import mf2_pkg::*;

	logic      store_we;
	mf2_addr_t store_addr;
	cpu_data_t store_data;

	mf2_bus_if bus ();

	//////////////////// Control
	mf2_control u_control (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mode     (mode),
		.key_nmi  (key_nmi),
		.m1       (m1),
		.io_wr    (io_wr),
		.mem_wr   (mem_wr),
		.mem_rd   (mem_rd),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.bus      (bus),
		.nmi      (nmi),
		.rom_en   (mf2_rom_en),
		.ram_en   (mf2_ram_en)
	);

	//////////////////// Snooper
	mf2_snoop u_snoop (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus),
		.store_we   (store_we),
		.store_addr (store_addr),
		.store_data (store_data)
	);

	//////////////////// RAM
	mf2_ram u_ram (
		.clk_sys    (clk_sys),
		.bus        (bus),
		.store_we   (store_we),
		.store_addr (store_addr),
		.store_data (store_data),
		.dout       (mf2_dout)
	);

endmodule

`default_nettype wire

//--- logic/mf2_ram.sv
/*
 * Multiface Two cartridge RAM
 * 8 KB single port, snooped stores ahead of window writes
 */
`timescale 1ns/1ps
`default_nettype none

`include "mf2_cfg.svh"

module mf2_ram (
	input  logic               clk_sys,
	mf2_bus_if.mem             bus,
	input  logic               store_we,
	input  mf2_pkg::mf2_addr_t store_addr,
	input  mf2_pkg::cpu_data_t store_data,
	output mf2_pkg::cpu_data_t dout
);
	import mf2_pkg::*;

	cpu_data_t ram [`MF2_RAM_DEPTH];
	mf2_addr_t ram_a;
	cpu_data_t ram_in;
	cpu_data_t ram_out;
	logic      ram_we;

	// Port register
	always_ff @(posedge clk_sys) begin
		if (store_we) begin
			ram_a  <= store_addr;       // Snooped register
			ram_in <= store_data;
			ram_we <= 1'b1;
		end else if (bus.mem_wr && bus.ram_en) begin
			ram_a  <= bus.addr[12:0];
			ram_in <= bus.data;
			ram_we <= 1'b1;
		end else begin
			ram_a  <= bus.addr[12:0];
			ram_we <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_a] <= ram_in;
			ram_out    <= ram_in;   // Write-through
		end else begin
			ram_out <= ram[ram_a];
		end
	end

	// Idle bus reads as 0xFF so it can be ANDed with other sources
	assign dout = (bus.ram_en && bus.mem_rd) ? ram_out : 8'hFF;

endmodule

`default_nettype wire

//--- logic/mf2_snoop.sv
/*
 * Hardware register snooper
 * Maps I/O writes to gate array, CRTC, 8255 and ROM ports onto RAM slots
 */
`timescale 1ns/1ps
`default_nettype none

`include "mf2_cfg.svh"

module mf2_snoop (
	input  logic               clk_sys,
	input  logic               reset,
	mf2_bus_if.snoop           bus,
	output logic               store_we,
	output mf2_pkg::mf2_addr_t store_addr,
	output mf2_pkg::cpu_data_t store_data
);
	import mf2_pkg::*;

	logic [4:0] pen_idx_q;   // Bit 4 selects the border
	logic [3:0] crtc_reg_q;
	logic       hit;
	logic       pen_sel;
	logic       crtc_sel;
	mf2_addr_t  loc;

	assign pen_sel  = (bus.addr[15:8] == `MF2_PORT_GA) && (bus.data[7:6] == 2'b00);
	assign crtc_sel = (bus.addr[15:8] == `MF2_PORT_CRTC_SEL);

	//////////////////// Slot decode
	always_comb begin
		hit = 1'b1;
		loc = '0;
		case (bus.addr[15:8])
			`MF2_PORT_GA: begin
				case (bus.data[7:6])
					2'b00: loc = `MF2_LOC_PEN;
					2'b01: begin
						if (pen_idx_q[4])
							loc = `MF2_LOC_BORDER;
						else
							loc = `MF2_LOC_PALETTE_BASE + mf2_addr_t'(pen_idx_q[3:0]);
					end
					2'b10: loc = `MF2_LOC_MODE;
					default: loc = `MF2_LOC_BANK;
				endcase
			end
			`MF2_PORT_CRTC_SEL: loc = `MF2_LOC_CRTC_SEL;
			`MF2_PORT_CRTC_VAL: loc = `MF2_LOC_CRTC_BASE + mf2_addr_t'(crtc_reg_q);
			`MF2_PORT_PPI:      loc = `MF2_LOC_PPI;
			`MF2_PORT_UROM:     loc = `MF2_LOC_UROM;
			default:            hit = 1'b0;     // Not a tracked port
		endcase
	end

	//////////////////// Request and index latches
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			store_we   <= 1'b0;
			pen_idx_q  <= '0;
			crtc_reg_q <= '0;
		end else begin
			store_we <= bus.io_wr_pulse & hit;
			if (bus.io_wr_pulse && pen_sel)
				pen_idx_q <= bus.data[4:0];
			if (bus.io_wr_pulse && crtc_sel)
				crtc_reg_q <= bus.data[3:0];
		end
	end

	// Slot and byte held with the request
	always_ff @(posedge clk_sys) begin
		if (bus.io_wr_pulse) begin
			store_addr <= loc;
			store_data <= bus.data;
		end
	end

endmodule

`default_nettype wire

//--- logic/mf2_control.sv
/*
 * Multiface Two control
 * Strobe edges, NMI and paging FSM, hide flag and ROM/RAM window decode
 */
`timescale 1ns/1ps
`default_nettype none

`include "mf2_cfg.svh"

module mf2_control (
	input  logic               clk_sys,
	input  logic               reset,
	input  mf2_pkg::mf2_mode_t mode,
	input  logic               key_nmi,
	input  logic               m1,
	input  logic               io_wr,
	input  logic               mem_wr,
	input  logic               mem_rd,
	input  mf2_pkg::cpu_addr_t cpu_addr,
	input  mf2_pkg::cpu_data_t cpu_dout,
	mf2_bus_if.ctrl            bus,
	output logic               nmi,
	output logic               rom_en,
	output logic               ram_en
);
	import mf2_pkg::*;

	logic       key_q;
	logic       key_qq;
	logic       m1_q;
	logic       m1_qq;
	logic       io_wr_q;
	logic       io_wr_qq;
	logic       key_rise;
	logic       m1_rise;
	logic       io_wr_pulse;
	logic       fetch_nmi;
	logic       fetch_hide;
	logic       page_wr;
	logic       paged;
	logic       hide_q;
	mf2_state_t state_q;
	mf2_state_t state_d;

	//////////////////// Edges
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_q    <= 1'b0;
			key_qq   <= 1'b0;
			m1_q     <= 1'b0;
			m1_qq    <= 1'b0;
			io_wr_q  <= 1'b0;
			io_wr_qq <= 1'b0;
		end else begin
			key_q    <= key_nmi;
			key_qq   <= key_q;
			m1_q     <= m1;
			m1_qq    <= m1_q;
			io_wr_q  <= io_wr;
			io_wr_qq <= io_wr_q;
		end
	end

	assign key_rise    = key_q & ~key_qq;
	assign m1_rise     = m1_q & ~m1_qq;
	assign io_wr_pulse = io_wr_q & ~io_wr_qq;

	// Vector fetches and FEE8/FEEA writes
	assign fetch_nmi  = m1_rise && (cpu_addr == `MF2_NMI_VECTOR) && (state_q == MF2_NMI_PENDING);
	assign fetch_hide = m1_rise && (cpu_addr == `MF2_HIDE_VECTOR) && paged;
	assign page_wr    = io_wr_pulse && (cpu_addr[15:2] == `MF2_PAGE_PORT_HI);

	//////////////////// Paging FSM
	always_comb begin
		state_d = state_q;
		case (state_q)
			MF2_IDLE: begin
				if (page_wr && !cpu_addr[1] && !hide_q)
					state_d = MF2_PAGED;        // FEE8
				else if (key_rise && !mode[1])
					state_d = MF2_NMI_PENDING;
			end
			MF2_NMI_PENDING: begin
				if (fetch_nmi)
					state_d = MF2_PAGED;
			end
			MF2_PAGED: begin
				// FEEA pages out
				if (page_wr && cpu_addr[1])
					state_d = MF2_IDLE;
			end
			default: state_d = MF2_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state_q <= MF2_IDLE;
			hide_q  <= (mode != 2'b00);
		end else begin
			state_q <= state_d;
			if (fetch_nmi)
				hide_q <= 1'b0;     // NMI entry reveals the cartridge
			else if (fetch_hide)
				hide_q <= 1'b1;
		end
	end

	//////////////////// Windows
	assign paged  = (state_q == MF2_PAGED);
	assign nmi    = (state_q == MF2_NMI_PENDING);
	assign rom_en = paged && (cpu_addr[15:13] == `MF2_ROM_WINDOW);
	assign ram_en = paged && (cpu_addr[15:13] == `MF2_RAM_WINDOW);

	assign bus.addr        = cpu_addr;
	assign bus.data        = cpu_dout;
	assign bus.io_wr_pulse = io_wr_pulse;
	assign bus.mem_wr      = mem_wr;
	assign bus.mem_rd      = mem_rd;
	assign bus.ram_en      = ram_en;

endmodule

`default_nettype wire

//--- logic/mf2_bus_if.sv
/*
 * Internal Multiface bus
 * CPU bus, I/O write pulse and RAM window select shared by the sub-blocks
 */
`timescale 1ns/1ps
`default_nettype none

interface mf2_bus_if;
	import mf2_pkg::*;

	cpu_addr_t addr;
	cpu_data_t data;
	logic      io_wr_pulse;  // One cycle after io_wr rises
	logic      mem_wr;
	logic      mem_rd;
	logic      ram_en;       // Paged and address in 0x2000-0x3FFF

	// Owner of the bus
	modport ctrl (
		output addr,
		output data,
		output io_wr_pulse,
		output mem_wr,
		output mem_rd,
		output ram_en
	);

	// Hardware register snooper
	modport snoop (
		input addr,
		input data,
		input io_wr_pulse
	);

	// Cartridge RAM
	modport mem (
		input addr,
		input data,
		input mem_wr,
		input mem_rd,
		input ram_en
	);

endinterface

`default_nettype wire

//--- logic/mf2_pkg.sv
/*
 * Multiface Two types
 * Bus vectors, cartridge RAM offset, operator mode and paging states
 */
`default_nettype none

package mf2_pkg;

	// Z80 bus
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// Offset into the 8 KB cartridge RAM
	typedef logic [12:0] mf2_addr_t;

	// Operator setting
	// 0 enabled, 1 hidden, 2 or 3 disabled
	typedef logic [1:0]  mf2_mode_t;

	typedef enum logic [1:0] {
		MF2_IDLE        = 2'd0, // Not paged, no NMI
		MF2_NMI_PENDING = 2'd1, // Waiting for the 0x0066 fetch
		MF2_PAGED       = 2'd2  // ROM and RAM visible
	} mf2_state_t;

endpackage

`default_nettype wire

//--- logic/mf2_cfg.svh
/*
 * Multiface Two constants
 * Vectors, port decodes and shadow locations fixed by the CPC hardware
 */
`ifndef MF2_CFG_SVH
`define MF2_CFG_SVH

`define MF2_NMI_VECTOR        16'h0066
`define MF2_HIDE_VECTOR       16'h0065
`define MF2_PAGE_PORT_HI      14'h3FBA // FEE8 and FEEA without bit 1
`define MF2_ROM_WINDOW        3'b000
`define MF2_RAM_WINDOW        3'b001
`define MF2_RAM_DEPTH         8192

// Shadow locations inside the cartridge RAM
`define MF2_LOC_PEN           13'h1FCF
`define MF2_LOC_BORDER        13'h1FDF
`define MF2_LOC_PALETTE_BASE  13'h1F90
`define MF2_LOC_MODE          13'h1FEF
`define MF2_LOC_BANK          13'h1FFF
`define MF2_LOC_CRTC_SEL      13'h1CFF
`define MF2_LOC_CRTC_BASE     13'h1DB0
`define MF2_LOC_PPI           13'h17FF
`define MF2_LOC_UROM          13'h1AAC

// I/O port high bytes
`define MF2_PORT_GA           8'h7F
`define MF2_PORT_CRTC_SEL     8'hBC
`define MF2_PORT_CRTC_VAL     8'hBD
`define MF2_PORT_PPI          8'hF7
`define MF2_PORT_UROM         8'hDF

`endif
